// File: hispi_pkg.sv
// shared widths, sync constants, code word union and fifo entry layout for the hispi receiver
package hispi_pkg;

    localparam int PIXEL_BITS      = 12;                      // one pixel / code word
    localparam int LANE_BITS       = 2;                       // deserialized bits per lane per clock
    localparam int CHUNKS_PER_WORD = PIXEL_BITS / LANE_BITS;  // also the number of bit offsets
    localparam int NUM_LANES       = 4;

    // sync pattern is FFF, 000, 000 on every lane
    localparam logic [PIXEL_BITS-1:0] SYNC_WORD0 = 12'hFFF;
    localparam logic [PIXEL_BITS-1:0] SYNC_WORD1 = 12'h000;

    // code word following the sync pattern
    typedef struct packed {
        logic [6:0] reserved;  // bits 11..5, zero
        logic       embed;     // embedded data line
        logic       eof;       // end of frame, ends the line too
        logic       eol;       // end of line
        logic       sof;       // start of frame, starts a line too
        logic       sol;       // start of line
    } sync_code_t;

    // same 12 bits seen as data or as a code
    typedef union packed {
        logic [PIXEL_BITS-1:0] pixel;
        sync_code_t            code;
    } hispi_word_t;

    // fifo entry is the pixel with three flags on top
    localparam int FIFO_ENTRY_BITS   = PIXEL_BITS + 3;
    localparam int ENTRY_FRAME_FIRST = PIXEL_BITS;      // first pixel of a frame
    localparam int ENTRY_LINE_LAST   = PIXEL_BITS + 1;  // last pixel this lane has in the line
    localparam int ENTRY_FRAME_LAST  = PIXEL_BITS + 2;  // last pixel this lane has in the frame

endpackage

// File: hispi_lane_decoder.sv
// one hispi lane: finds word alignment on the sync pattern, decodes codes and tags pixels
`timescale 1ns/1ps

module hispi_lane_decoder import hispi_pkg::*; (
    input  logic                  ipclk,
    input  logic                  prst,
    input  logic [LANE_BITS-1:0]  chunk,        // msb pair first
    output logic [PIXEL_BITS-1:0] word,         // held pixel
    output logic                  word_valid,   // one cycle per released pixel
    output logic                  frame_first,
    output logic                  line_last,
    output logic                  frame_last,
    output logic                  line_start,   // strobe at a start code
    output logic                  line_embed    // valid with line_start
);

    localparam int WIN_BITS = 3 * PIXEL_BITS;           // three words of history
    localparam int CNT_BITS = $clog2(CHUNKS_PER_WORD);
    localparam logic [WIN_BITS-1:0] SYNC_PATTERN = {SYNC_WORD0, SYNC_WORD1, SYNC_WORD1};

    localparam logic [1:0] ST_HUNT = 2'd0;  // waiting for sync, words ignored
    localparam logic [1:0] ST_CODE = 2'd1;  // next word is a code
    localparam logic [1:0] ST_PIX  = 2'd2;  // words are pixels

    logic [WIN_BITS-1:0]   window;         // chunk shift window
    logic [CNT_BITS-1:0]   cnt;            // chunks of current word in window
    logic                  locked;
    logic [1:0]            state;
    logic [PIXEL_BITS-1:0] held;           // pixel waiting for its successor
    logic                  held_valid;
    logic                  held_first;     // held pixel opens a frame
    logic                  first_pending;  // next pixel opens a frame

    hispi_word_t           cur;            // newest complete word
    logic                  sync_hit;
    logic                  word_done;
    logic                  code_done;
    logic                  pix_done;
    logic                  is_start;

    assign cur = window[PIXEL_BITS-1:0];

    // window is compared on every chunk, so every bit offset gets tried while unlocked;
    // once locked only the word boundary counts
    assign sync_hit  = (window == SYNC_PATTERN) && (!locked || cnt == '0);
    assign word_done = locked && (cnt == '0) && !sync_hit;
    assign code_done = word_done && (state == ST_CODE);
    assign pix_done  = word_done && (state == ST_PIX) && (cur.pixel != SYNC_WORD0);
    assign is_start  = cur.code.sol || cur.code.sof;

    // held pixel goes out when the next word is known
    assign word        = held;
    assign word_valid  = held_valid && (pix_done || code_done);
    assign frame_first = held_first;
    assign line_last   = held_valid && code_done;              // followed by sync
    assign frame_last  = held_valid && code_done && cur.code.eof;
    assign line_start  = code_done && is_start;
    assign line_embed  = cur.code.embed;

    always_ff @(posedge ipclk or posedge prst) begin
        if (prst) begin
            window        <= '0;
            cnt           <= '0;
            locked        <= 1'b0;
            state         <= ST_HUNT;
            held_valid    <= 1'b0;
            held_first    <= 1'b0;
            first_pending <= 1'b0;
        end else begin
            window <= {window[WIN_BITS-LANE_BITS-1:0], chunk};  // newest chunk at lsb

            if (sync_hit) begin
                cnt    <= CNT_BITS'(1);   // first chunk of the code is shifting in now
                locked <= 1'b1;
                state  <= ST_CODE;
            end else begin
                if (cnt == CNT_BITS'(CHUNKS_PER_WORD - 1))
                    cnt <= '0;            // word complete next cycle
                else
                    cnt <= cnt + 1'b1;

                if (code_done) begin
                    state         <= is_start ? ST_PIX : ST_HUNT;  // end code -> skip to sync
                    first_pending <= is_start && cur.code.sof;
                end else if (word_done && state == ST_PIX && cur.pixel == SYNC_WORD0) begin
                    state <= ST_HUNT;     // FFF opens the trailing sync, pixel stays held
                end
            end

            if (code_done) begin
                held_valid <= 1'b0;       // released as line_last
            end else if (pix_done) begin
                held_valid    <= 1'b1;
                held_first    <= first_pending;
                first_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge ipclk) begin
        if (pix_done)
            held <= cur.pixel;
    end

endmodule

// File: hispi_lane_fifo.sv
// per-lane fifo of tagged pixels, drops embedded-data lines when asked to
`timescale 1ns/1ps

module hispi_lane_fifo import hispi_pkg::*; #(
    parameter int DEPTH = 16   // power of two, 4 or more
) (
    input  logic                       ipclk,
    input  logic                       prst,
    input  logic [PIXEL_BITS-1:0]      word,
    input  logic                       word_valid,
    input  logic                       frame_first,
    input  logic                       line_last,
    input  logic                       frame_last,
    input  logic                       line_start,
    input  logic                       line_embed,
    input  logic                       ignore_embedded,  // sampled at each start code
    input  logic                       pop,
    output logic [FIFO_ENTRY_BITS-1:0] entry,            // head, combinational
    output logic                       empty,
    output logic                       overflow          // sticky
);

    localparam int AW = $clog2(DEPTH);

    logic [FIFO_ENTRY_BITS-1:0] mem [DEPTH];
    logic [AW:0]                wr_ptr;       // extra bit tells full from empty
    logic [AW:0]                rd_ptr;
    logic                       discard;      // current line is dropped
    logic                       first_carry;  // frame start seen on a dropped line
    logic                       full;
    logic                       keep;
    logic                       wr_en;
    logic [FIFO_ENTRY_BITS-1:0] wr_entry;

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign keep  = word_valid && !discard;
    assign wr_en = keep && !full;
    assign entry = mem[rd_ptr[AW-1:0]];

    always_comb begin
        wr_entry                    = '0;
        wr_entry[PIXEL_BITS-1:0]    = word;
        wr_entry[ENTRY_FRAME_FIRST] = frame_first || first_carry;  // moved past dropped lines
        wr_entry[ENTRY_LINE_LAST]   = line_last;
        wr_entry[ENTRY_FRAME_LAST]  = frame_last;
    end

    always_ff @(posedge ipclk or posedge prst) begin
        if (prst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            discard     <= 1'b0;
            first_carry <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;  // merge only pops a non-empty fifo
            if (line_start)
                discard <= line_embed && ignore_embedded;
            if (word_valid && discard && frame_first)
                first_carry <= 1'b1;
            else if (wr_en)
                first_carry <= 1'b0;
            if (keep && full)
                overflow <= 1'b1;         // pixel lost, no back-pressure to the sensor
        end
    end

    always_ff @(posedge ipclk) begin
        if (wr_en)
            mem[wr_ptr[AW-1:0]] <= wr_entry;
    end

endmodule

// File: hispi_lane_merge.sv
// reads the lane fifos in rotation and forms the pixel stream with hact, sof and eof
`timescale 1ns/1ps

module hispi_lane_merge import hispi_pkg::*; (
    input  logic                                 ipclk,
    input  logic                                 prst,
    input  logic [NUM_LANES*FIFO_ENTRY_BITS-1:0] entries,  // lane i in slice i
    input  logic [NUM_LANES-1:0]                 empty,
    output logic [NUM_LANES-1:0]                 pop,
    output logic [PIXEL_BITS-1:0]                pxd,
    output logic                                 pxd_valid,
    output logic                                 hact,
    output logic                                 sof,
    output logic                                 eof
);

    logic [NUM_LANES-1:0]       sel;         // one-hot current lane
    logic [FIFO_ENTRY_BITS-1:0] head;        // head entry of current lane
    logic                       take;        // sample head this cycle
    logic                       line_done;   // lane 3 line_last went out
    logic                       frame_done;  // lane 3 frame_last went out

    always_comb begin
        head = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (sel[i])
                head = head | entries[i*FIFO_ENTRY_BITS +: FIFO_ENTRY_BITS];
        end
    end

    // one idle cycle after a line end lets hact drop between lines
    assign take = |(sel & ~empty) && !line_done;

    always_ff @(posedge ipclk or posedge prst) begin
        if (prst) begin
            sel        <= NUM_LANES'(1);  // lane 0 first
            pop        <= '0;
            pxd_valid  <= 1'b0;
            hact       <= 1'b0;
            sof        <= 1'b0;
            eof        <= 1'b0;
            line_done  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            pop        <= take ? sel : '0;  // pop lands with pxd_valid
            pxd_valid  <= take;
            sof        <= take && head[ENTRY_FRAME_FIRST];
            line_done  <= take && sel[NUM_LANES-1] && head[ENTRY_LINE_LAST];
            frame_done <= take && sel[NUM_LANES-1] && head[ENTRY_FRAME_LAST];
            eof        <= frame_done;       // cycle after the last pixel

            if (take)
                sel <= {sel[NUM_LANES-2:0], sel[NUM_LANES-1]};  // next lane

            if (take)
                hact <= 1'b1;
            else if (line_done)
                hact <= 1'b0;               // held through stalls
        end
    end

    always_ff @(posedge ipclk) begin
        if (take)
            pxd <= head[PIXEL_BITS-1:0];
    end

endmodule

// File: hispi_rx_top.sv
// four-lane hispi packetized-sp receiver top, decoders and fifos per lane feeding the merge
`timescale 1ns/1ps

module hispi_rx_top import hispi_pkg::*; #(
    parameter int FIFO_DEPTH = 16   // per lane, covers a lane's line share plus skew
) (
    input  logic                           ipclk,
    input  logic                           prst,
    input  logic [NUM_LANES*LANE_BITS-1:0] lane_data,        // lane i in slice i
    input  logic                           ignore_embedded,
    output logic [PIXEL_BITS-1:0]          pxd,
    output logic                           pxd_valid,
    output logic                           hact,
    output logic                           sof,
    output logic                           eof
);

    logic [NUM_LANES*PIXEL_BITS-1:0]      dec_word;
    logic [NUM_LANES-1:0]                 dec_valid;
    logic [NUM_LANES-1:0]                 dec_first;
    logic [NUM_LANES-1:0]                 dec_line_last;
    logic [NUM_LANES-1:0]                 dec_frame_last;
    logic [NUM_LANES-1:0]                 dec_line_start;
    logic [NUM_LANES-1:0]                 dec_line_embed;
    logic [NUM_LANES*FIFO_ENTRY_BITS-1:0] fifo_entry;
    logic [NUM_LANES-1:0]                 fifo_empty;
    logic [NUM_LANES-1:0]                 fifo_pop;
    logic [NUM_LANES-1:0]                 fifo_overflow;    // watched by the bound checker

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        hispi_lane_decoder u_dec (
            .ipclk       (ipclk),
            .prst        (prst),
            .chunk       (lane_data[i*LANE_BITS +: LANE_BITS]),
            .word        (dec_word[i*PIXEL_BITS +: PIXEL_BITS]),
            .word_valid  (dec_valid[i]),
            .frame_first (dec_first[i]),
            .line_last   (dec_line_last[i]),
            .frame_last  (dec_frame_last[i]),
            .line_start  (dec_line_start[i]),
            .line_embed  (dec_line_embed[i])
        );

        hispi_lane_fifo #(
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .ipclk           (ipclk),
            .prst            (prst),
            .word            (dec_word[i*PIXEL_BITS +: PIXEL_BITS]),
            .word_valid      (dec_valid[i]),
            .frame_first     (dec_first[i]),
            .line_last       (dec_line_last[i]),
            .frame_last      (dec_frame_last[i]),
            .line_start      (dec_line_start[i]),
            .line_embed      (dec_line_embed[i]),
            .ignore_embedded (ignore_embedded),
            .pop             (fifo_pop[i]),
            .entry           (fifo_entry[i*FIFO_ENTRY_BITS +: FIFO_ENTRY_BITS]),
            .empty           (fifo_empty[i]),
            .overflow        (fifo_overflow[i])
        );
    end

    hispi_lane_merge u_merge (
        .ipclk     (ipclk),
        .prst      (prst),
        .entries   (fifo_entry),
        .empty     (fifo_empty),
        .pop       (fifo_pop),
        .pxd       (pxd),
        .pxd_valid (pxd_valid),
        .hact      (hact),
        .sof       (sof),
        .eof       (eof)
    );

endmodule

// File: hispi_rx_assertions.sv
// output protocol checks for the hispi receiver, bound into hispi_rx_top
`timescale 1ns/1ps

module hispi_rx_assertions import hispi_pkg::*; (
    input logic                 ipclk,
    input logic                 prst,
    input logic                 pxd_valid,
    input logic                 hact,
    input logic                 sof,
    input logic                 eof,
    input logic [NUM_LANES-1:0] fifo_overflow
);

    // eof comes after the closing line, never with a pixel
    a_valid_in_line: assert property (@(posedge ipclk) disable iff (prst)
        pxd_valid |-> hact && !eof)
        else $error("pixel strobe outside an active line");

    // sof opens a line so hact was low just before
    a_sof_on_pixel: assert property (@(posedge ipclk) disable iff (prst)
        sof |-> pxd_valid && !$past(hact))
        else $error("sof without a pixel that opens a line");

    a_no_overflow: assert property (@(posedge ipclk) disable iff (prst)
        fifo_overflow == '0)
        else $error("lane fifo overflow, pixels lost");

    // outputs idle right after a reset cycle
    a_reset_idle: assert property (@(posedge ipclk)
        prst |=> !hact && !sof && !eof)
        else $error("outputs active after reset");

endmodule

bind hispi_rx_top hispi_rx_assertions u_assertions (
    .ipclk         (ipclk),
    .prst          (prst),
    .pxd_valid     (pxd_valid),
    .hact          (hact),
    .sof           (sof),
    .eof           (eof),
    .fifo_overflow (fifo_overflow)
);

// File: hispi_rx_tb.sv
// testbench for the four-lane hispi receiver, lfsr stimulus checked against a reference model
`timescale 1ns/1ps

module hispi_rx_tb import hispi_pkg::*; ();

    localparam logic [PIXEL_BITS-1:0] CODE_SOL  = 12'h001;
    localparam logic [PIXEL_BITS-1:0] CODE_SOF  = 12'h002;
    localparam logic [PIXEL_BITS-1:0] CODE_EOL  = 12'h004;
    localparam logic [PIXEL_BITS-1:0] CODE_EOF  = 12'h008;
    localparam logic [PIXEL_BITS-1:0] CODE_EMB  = 12'h010;
    localparam logic [PIXEL_BITS-1:0] PIX_SUBST = 12'hFFE;  // stands in for reserved FFF
    localparam int                    MAX_CHUNKS = 4096;

    logic                           ipclk;
    logic                           prst;
    logic [NUM_LANES*LANE_BITS-1:0] lane_data;
    logic                           ignore_embedded;
    logic [PIXEL_BITS-1:0]          pxd;
    logic                           pxd_valid;
    logic                           hact;
    logic                           sof;
    logic                           eof;

    logic [LANE_BITS-1:0]  lane_chunks [NUM_LANES][MAX_CHUNKS];  // serialized lane streams
    int                    lane_len [NUM_LANES];
    logic [PIXEL_BITS-1:0] sent_pix [$];                        // all pixels in line order
    int                    line_npix [$];
    bit                    line_emb [$];
    bit                    line_fs [$];                         // line opens a frame
    bit                    line_fe [$];                         // line closes a frame
    logic [PIXEL_BITS-1:0] exp_pix [$];
    bit                    exp_sof [$];
    bit                    exp_last [$];                        // last pixel of a frame
    int                    exp_lines;
    int                    exp_frames;
    int                    exp_sofs;
    int                    out_idx;
    int                    sof_cnt;
    int                    eof_cnt;
    int                    hact_cnt;
    bit                    eof_due;
    bit                    hact_q;
    bit                    checking;
    int                    cyc;
    int                    cyc_limit;
    logic [31:0]           lfsr_state;

    always #5 ipclk = ~ipclk;  // 10 ns period

    hispi_rx_top #(
        .FIFO_DEPTH (16)
    ) UUT (
        .ipclk           (ipclk),
        .prst            (prst),
        .lane_data       (lane_data),
        .ignore_embedded (ignore_embedded),
        .pxd             (pxd),
        .pxd_valid       (pxd_valid),
        .hact            (hact),
        .sof             (sof),
        .eof             (eof)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // expected output: lines in order, embedded ones gone when ignored
    function automatic void build_reference(input logic ign);
        int pos;
        bit sof_pending;
        pos         = 0;
        sof_pending = 1'b0;
        exp_pix.delete();
        exp_sof.delete();
        exp_last.delete();
        exp_lines  = 0;
        exp_frames = 0;
        exp_sofs   = 0;
        for (int l = 0; l < line_npix.size(); l++) begin
            if (line_fs[l])
                sof_pending = 1'b1;  // survives a dropped first line
            if (!(ign && line_emb[l])) begin
                exp_lines++;
                if (line_fe[l])
                    exp_frames++;
                for (int k = 0; k < line_npix[l]; k++) begin
                    exp_pix.push_back(sent_pix[pos + k]);
                    exp_sof.push_back(sof_pending);
                    if (sof_pending)
                        exp_sofs++;
                    sof_pending = 1'b0;
                    exp_last.push_back(line_fe[l] && k == line_npix[l] - 1);
                end
            end
            pos += line_npix[l];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic clear_stimulus();
        sent_pix.delete();
        line_npix.delete();
        line_emb.delete();
        line_fs.delete();
        line_fe.delete();
        for (int l = 0; l < NUM_LANES; l++)
            lane_len[l] = 0;
    endtask

    task automatic push_word(input int lane, input logic [PIXEL_BITS-1:0] w);
        for (int c = 0; c < CHUNKS_PER_WORD; c++) begin
            lane_chunks[lane][lane_len[lane]] = w[PIXEL_BITS-1-LANE_BITS*c -: LANE_BITS];
            lane_len[lane]++;  // msb pair first
        end
    endtask

    task automatic push_sync(input int lane);
        push_word(lane, SYNC_WORD0);
        push_word(lane, SYNC_WORD1);
        push_word(lane, SYNC_WORD1);
    endtask

    task automatic add_skew(input bit random_skew);
        int n;
        for (int l = 0; l < NUM_LANES; l++) begin
            n = random_skew ? int'(rand_bits(3) % 6) : 0;  // idle zero chunks
            repeat (n) begin
                lane_chunks[l][lane_len[l]] = '0;
                lane_len[l]++;
            end
        end
    endtask

    // pixel k of a line goes to lane k mod 4, frame start flagged on lane 0 only
    task automatic add_line(input int npix, input bit emb, input bit fs, input bit fe,
                            input bit random_pix);
        logic [PIXEL_BITS-1:0] code;
        logic [PIXEL_BITS-1:0] p;
        for (int l = 0; l < NUM_LANES; l++) begin
            push_sync(l);
            code = (fs && l == 0) ? CODE_SOF : CODE_SOL;
            if (emb)
                code = code | CODE_EMB;
            push_word(l, code);
        end
        for (int k = 0; k < npix; k++) begin
            p = random_pix ? PIXEL_BITS'(rand_bits(PIXEL_BITS)) : PIXEL_BITS'(12'h123 + k * 73);
            if (p == SYNC_WORD0)
                p = PIX_SUBST;
            sent_pix.push_back(p);
            push_word(k % NUM_LANES, p);
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            push_sync(l);
            push_word(l, fe ? CODE_EOF : CODE_EOL);
        end
        line_npix.push_back(npix);
        line_emb.push_back(emb);
        line_fs.push_back(fs);
        line_fe.push_back(fe);
    endtask

    task automatic run_case(input logic ign);
        int c;
        int total;
        int maxlen;
        build_reference(ign);
        total  = 0;
        maxlen = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            total += lane_len[l];
            if (lane_len[l] > maxlen)
                maxlen = lane_len[l];
        end
        @(negedge ipclk);
        prst            = 1'b1;
        ignore_embedded = ign;
        lane_data       = '0;
        repeat (2) @(negedge ipclk);
        check_value("pxd_valid", pxd_valid, 0);  // outputs idle in reset
        check_value("hact", hact, 0);
        check_value("sof", sof, 0);
        check_value("eof", eof, 0);
        @(posedge ipclk);
        out_idx   = 0;
        sof_cnt   = 0;
        eof_cnt   = 0;
        hact_cnt  = 0;
        eof_due   = 1'b0;
        hact_q    = 1'b0;
        cyc       = 0;
        cyc_limit = 2 * total + 200;
        checking  = 1'b1;
        @(negedge ipclk);
        prst = 1'b0;  // third reset cycle ends here
        c    = 0;
        while (!(c >= maxlen && out_idx == exp_pix.size() && !hact)) begin
            for (int l = 0; l < NUM_LANES; l++)
                lane_data[l*LANE_BITS +: LANE_BITS] = (c < lane_len[l]) ? lane_chunks[l][c] : '0;
            c++;
            @(negedge ipclk);
        end
        @(negedge ipclk);  // eof of the last frame is counted by now
        @(posedge ipclk);
        checking = 1'b0;
        check_value("sof count", sof_cnt, exp_sofs);
        check_value("eof count", eof_cnt, exp_frames);
        check_value("hact lines", hact_cnt, exp_lines);
    endtask

    // comparator, outputs are registered and stable at the falling edge
    always @(negedge ipclk) begin
        if (checking) begin
            check_value("eof", eof, eof_due);
            check_value("fifo_overflow", UUT.fifo_overflow, 0);
            eof_due = 1'b0;
            if (pxd_valid) begin
                if (out_idx < exp_pix.size()) begin
                    check_value("pxd", pxd, exp_pix[out_idx]);
                    check_value("sof", sof, exp_sof[out_idx]);
                    check_value("hact", hact, 1);
                    check_value("eof with pixel", eof, 0);  // frame end leaves a gap
                    if (exp_sof[out_idx])
                        check_value("hact before sof", hact_q, 0);  // frame opens a line
                    eof_due = exp_last[out_idx];
                end else begin
                    check_value("pxd_valid", pxd_valid, 0);  // more pixels than sent
                end
                out_idx++;
            end else begin
                check_value("sof", sof, 0);
            end
            if (sof)
                sof_cnt++;
            if (eof)
                eof_cnt++;
            if (hact && !hact_q)
                hact_cnt++;
            hact_q = hact;
        end
    end

    always @(negedge ipclk) begin
        if (checking) begin
            cyc++;
            if (cyc > cyc_limit) begin
                $display("timeout: output stream not complete after %0d cycles", cyc);
                $display("Checks failed");
                $fatal(1, "run ended by the cycle limit");
            end
        end
    end

    initial begin
        ipclk           = 1'b0;
        prst            = 1'b1;
        lane_data       = '0;
        ignore_embedded = 1'b0;
        checking        = 1'b0;
        lfsr_state      = 32'h8a5c_2206;

        clear_stimulus();  // one 32 pixel line, no skew
        add_skew(1'b0);
        add_line(32, 1'b0, 1'b1, 1'b1, 1'b0);
        run_case(1'b0);

        clear_stimulus();  // random skew moves the alignment offsets
        add_skew(1'b1);
        add_line(24, 1'b0, 1'b1, 1'b0, 1'b1);
        add_line(24, 1'b0, 1'b0, 1'b1, 1'b1);
        run_case(1'b0);

        clear_stimulus();  // single-line frames, sof and eof counts
        add_skew(1'b1);
        for (int f = 0; f < 4; f++)
            add_line(8, 1'b0, 1'b1, 1'b1, 1'b1);
        run_case(1'b0);

        clear_stimulus();  // embedded first lines, dropped then kept
        add_skew(1'b1);
        for (int f = 0; f < 2; f++) begin
            add_line(16, 1'b1, 1'b1, 1'b0, 1'b1);
            add_line(16, 1'b0, 1'b0, 1'b0, 1'b1);
            add_line(16, 1'b0, 1'b0, 1'b1, 1'b1);
        end
        run_case(1'b1);
        run_case(1'b0);

        clear_stimulus();  // three frames of four lines back to back
        add_skew(1'b1);
        for (int f = 0; f < 3; f++) begin
            for (int l = 0; l < 4; l++)
                add_line(16, 1'b0, l == 0, l == 3, 1'b1);
        end
        run_case(1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: sim.f
hispi_pkg.sv
hispi_lane_decoder.sv
hispi_lane_fifo.sv
hispi_lane_merge.sv
hispi_rx_top.sv
hispi_rx_assertions.sv
hispi_rx_tb.sv

// File: Bender.yml
package:
  name: hispi_rx

sources:
  - hispi_pkg.sv
  - hispi_lane_decoder.sv
  - hispi_lane_fifo.sv
  - hispi_lane_merge.sv
  - hispi_rx_top.sv
  - target: test
    files:
      - hispi_rx_assertions.sv
      - hispi_rx_tb.sv
